/* hw/ecc_mem_pkg.sv */
// shared widths, types and SEC-DED helpers for the ECC word memory
// referenced by scoped name from every RTL block
`default_nettype none

package ecc_mem_pkg;

   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;   // [5:0] hamming, [6] overall parity
   localparam int CODE_W = DATA_W + ECC_W;
   localparam int CNT_W  = 16;

   // data bits feeding each hamming check bit, [0] is check bit 0
   localparam logic [5:0][DATA_W-1:0] TAP_MASK = {
      32'hFC00_0000,
      32'h03FF_F800,
      32'h03FC_07F0,
      32'hE3C3_C78E,
      32'h9B33_366D,
      32'h56AA_AD5B
   };

   typedef struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
   } code_word_t;

   typedef enum logic [1:0] {
      ERR_NONE   = 2'd0,
      ERR_SINGLE = 2'd1,
      ERR_DOUBLE = 2'd2
   } err_kind_e;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      err_kind_e         err_kind;
      logic              valid;
   } rd_resp_t;

   function automatic logic [5:0] hamming_bits(input logic [DATA_W-1:0] d);
      logic [5:0] h;
      for (int k = 0; k < 6; k++) begin
         h[k] = ^(d & TAP_MASK[k]);
      end
      return h;
   endfunction

   // code position p+1 lives at vector index p, check bits on powers of two
   function automatic logic [CODE_W-1:0] to_pos(input code_word_t cw);
      return {cw.ecc[6], cw.data[31:26], cw.ecc[5], cw.data[25:11], cw.ecc[4],
              cw.data[10:4], cw.ecc[3], cw.data[3:1], cw.ecc[2], cw.data[0], cw.ecc[1:0]};
   endfunction

   function automatic code_word_t from_pos(input logic [CODE_W-1:0] p);
      code_word_t cw;
      cw.ecc  = {p[38], p[31], p[15], p[7], p[3], p[1], p[0]};
      cw.data = {p[37:32], p[30:16], p[14:8], p[6:4], p[2]};
      return cw;
   endfunction

endpackage

`default_nettype wire

/* hw/ecc_write_port.sv */
// write side of the ECC memory: encodes the data word, applies the
// fault-injection mask and registers the write toward the word store
`default_nettype none

module ecc_write_port #(
   parameter int DEPTH = 16
) (
   input  wire logic                                clk,
   input  wire logic                                rst_l,
   input  wire logic                                wr_en,
   input  wire logic [$clog2(DEPTH)-1:0]            wr_addr,
   input  wire logic [ecc_mem_pkg::DATA_W-1:0]      wr_data,
   input  wire logic [ecc_mem_pkg::CODE_W-1:0]      inject_mask,
   output logic                                     st_wr_en,
   output logic [$clog2(DEPTH)-1:0]                 st_wr_addr,
   output ecc_mem_pkg::code_word_t                  st_wr_word
);

   logic [5:0]              ham_bits;
   logic                    par_bit;
   ecc_mem_pkg::code_word_t enc_word;
   ecc_mem_pkg::code_word_t mask_word;
   ecc_mem_pkg::code_word_t inj_word;

   // check bits 0..5 from the tap lists, bit 6 covers data and hamming bits
   assign ham_bits = ecc_mem_pkg::hamming_bits(wr_data);
   assign par_bit  = (^wr_data) ^ (^ham_bits);

   always_comb begin
      enc_word.data = wr_data;
      enc_word.ecc  = {par_bit, ham_bits};
   end

   // mask is in code position order, so remap it onto the ecc/data fields
   assign mask_word = ecc_mem_pkg::from_pos(inject_mask);
   assign inj_word  = enc_word ^ mask_word;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         st_wr_en <= 1'b0;
      end else begin
         st_wr_en <= wr_en;
      end
   end

   // payload only moves with a write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         st_wr_addr <= wr_addr;
         st_wr_word <= inj_word;
      end
   end

endmodule

`default_nettype wire

/* hw/ecc_word_store.sv */
// register array holding the 39-bit code words
// one write and one registered read per cycle, read sees the old word on a collision
`default_nettype none

module ecc_word_store #(
   parameter int DEPTH = 16
) (
   input  wire logic                       clk,
   input  wire logic                       rst_l,
   input  wire logic                       st_wr_en,
   input  wire logic [$clog2(DEPTH)-1:0]   st_wr_addr,
   input  wire ecc_mem_pkg::code_word_t    st_wr_word,
   input  wire logic                       st_rd_en,
   input  wire logic [$clog2(DEPTH)-1:0]   st_rd_addr,
   output ecc_mem_pkg::code_word_t         st_rd_word
);

   localparam int AW = $clog2(DEPTH);

   ecc_mem_pkg::code_word_t mem [DEPTH];

   logic          wr_in_range;
   logic [AW-1:0] rd_idx;

   // non power of two depths leave the top addresses unused
   assign wr_in_range = (int'(st_wr_addr) < DEPTH);
   assign rd_idx      = st_rd_addr;

   always_ff @(posedge clk) begin
      if (st_wr_en && wr_in_range) begin
         mem[st_wr_addr] <= st_wr_word;
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         st_rd_word <= '0;   // decodes as a clean zero word
      end else if (st_rd_en) begin
         st_rd_word <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

/* hw/ecc_read_port.sv */
// read side of the ECC memory: issues the store read, decodes the returned
// code word (SEC-DED or detect-only) and keeps saturating error counts
`default_nettype none

module ecc_read_port #(
   parameter int DEPTH = 16
) (
   input  wire logic                            clk,
   input  wire logic                            rst_l,
   input  wire logic                            rd_en,
   input  wire logic [$clog2(DEPTH)-1:0]        rd_addr,
   input  wire logic                            detect_only,
   output logic                                 st_rd_en,
   output logic [$clog2(DEPTH)-1:0]             st_rd_addr,
   input  wire ecc_mem_pkg::code_word_t         st_rd_word,
   output ecc_mem_pkg::rd_resp_t                rd_resp,
   output logic [ecc_mem_pkg::CNT_W-1:0]        single_count,
   output logic [ecc_mem_pkg::CNT_W-1:0]        double_count
);

   localparam logic [ecc_mem_pkg::CNT_W-1:0] CNT_MAX = '1;

   logic                              word_valid;   // store output is live
   logic [5:0]                        syn_ham;
   logic                              syn_par;
   logic [6:0]                        syndrome;
   logic [ecc_mem_pkg::CODE_W-1:0]    err_mask;
   logic [ecc_mem_pkg::CODE_W-1:0]    raw_pos;
   logic [ecc_mem_pkg::CODE_W-1:0]    fix_pos;
   ecc_mem_pkg::code_word_t           fix_word;
   ecc_mem_pkg::err_kind_e            dec_kind;
   logic [ecc_mem_pkg::DATA_W-1:0]    resp_data;
   ecc_mem_pkg::err_kind_e            resp_kind;
   logic                              resp_valid;

   // request goes straight to the store, which registers it
   assign st_rd_en   = rd_en;
   assign st_rd_addr = rd_addr;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         word_valid <= 1'b0;
      end else begin
         word_valid <= rd_en;
      end
   end

   // syndrome: recomputed check bits against the stored ones
   assign syn_ham  = ecc_mem_pkg::hamming_bits(st_rd_word.data) ^ st_rd_word.ecc[5:0];
   assign syn_par  = ((^st_rd_word.data) ^ (^st_rd_word.ecc)) & ~detect_only;
   assign syndrome = {syn_par, syn_ham};

   always_comb begin
      if (syndrome == 7'd0) begin
         dec_kind = ecc_mem_pkg::ERR_NONE;
      end else if (syn_par) begin
         dec_kind = ecc_mem_pkg::ERR_SINGLE;   // never taken in detect-only mode
      end else begin
         dec_kind = ecc_mem_pkg::ERR_DOUBLE;
      end
   end

   // one-hot flip at the position named by the hamming syndrome
   always_comb begin
      for (int i = 1; i <= ecc_mem_pkg::CODE_W; i++) begin
         err_mask[i-1] = (syn_ham == 6'(i));
      end
   end

   assign raw_pos  = ecc_mem_pkg::to_pos(st_rd_word);
   assign fix_pos  = (dec_kind == ecc_mem_pkg::ERR_SINGLE) ? (raw_pos ^ err_mask) : raw_pos;
   assign fix_word = ecc_mem_pkg::from_pos(fix_pos);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         resp_valid <= 1'b0;
         resp_kind  <= ecc_mem_pkg::ERR_NONE;
      end else begin
         resp_valid <= word_valid;
         if (word_valid) begin
            resp_kind <= dec_kind;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (word_valid) begin
         resp_data <= fix_word.data;
      end
   end

   assign rd_resp = '{data: resp_data, err_kind: resp_kind, valid: resp_valid};

   // counts load on the same edge as the response they belong to
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         single_count <= '0;
         double_count <= '0;
      end else if (word_valid) begin
         if (dec_kind == ecc_mem_pkg::ERR_SINGLE && single_count != CNT_MAX) begin
            single_count <= single_count + 1'b1;
         end
         if (dec_kind == ecc_mem_pkg::ERR_DOUBLE && double_count != CNT_MAX) begin
            double_count <= double_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/ecc_mem_top.sv */
// ECC-protected word memory: write port, code word store and read port
// DEPTH sets the number of words and is passed down to all three stages
`default_nettype none

module ecc_mem_top #(
   parameter int DEPTH = 16
) (
   input  wire logic                              clk,
   input  wire logic                              rst_l,
   input  wire logic                              wr_en,
   input  wire logic [$clog2(DEPTH)-1:0]          wr_addr,
   input  wire logic [ecc_mem_pkg::DATA_W-1:0]    wr_data,
   input  wire logic [ecc_mem_pkg::CODE_W-1:0]    inject_mask,
   input  wire logic                              rd_en,
   input  wire logic [$clog2(DEPTH)-1:0]          rd_addr,
   input  wire logic                              detect_only,
   output ecc_mem_pkg::rd_resp_t                  rd_resp,
   output logic [ecc_mem_pkg::CNT_W-1:0]          single_count,
   output logic [ecc_mem_pkg::CNT_W-1:0]          double_count
);

   localparam int AW = $clog2(DEPTH);

   logic                    st_wr_en;
   logic [AW-1:0]           st_wr_addr;
   ecc_mem_pkg::code_word_t st_wr_word;
   logic                    st_rd_en;
   logic [AW-1:0]           st_rd_addr;
   ecc_mem_pkg::code_word_t st_rd_word;

   ecc_write_port #(.DEPTH(DEPTH)) u_write_port (
      .clk         (clk),
      .rst_l       (rst_l),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .inject_mask (inject_mask),
      .st_wr_en    (st_wr_en),
      .st_wr_addr  (st_wr_addr),
      .st_wr_word  (st_wr_word)
   );

   ecc_word_store #(.DEPTH(DEPTH)) u_word_store (
      .clk        (clk),
      .rst_l      (rst_l),
      .st_wr_en   (st_wr_en),
      .st_wr_addr (st_wr_addr),
      .st_wr_word (st_wr_word),
      .st_rd_en   (st_rd_en),
      .st_rd_addr (st_rd_addr),
      .st_rd_word (st_rd_word)
   );

   ecc_read_port #(.DEPTH(DEPTH)) u_read_port (
      .clk          (clk),
      .rst_l        (rst_l),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .detect_only  (detect_only),
      .st_rd_en     (st_rd_en),
      .st_rd_addr   (st_rd_addr),
      .st_rd_word   (st_rd_word),
      .rd_resp      (rd_resp),
      .single_count (single_count),
      .double_count (double_count)
   );

endmodule

`default_nettype wire

/* verif/ecc_mem_clk_gen.sv */
// clock and reset source for the ECC memory testbench
// 10 unit clock period, rst_l held low for the first 10 rising edges
`default_nettype none

module ecc_mem_clk_gen (
   output logic clk,
   output logic rst_l
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rst_l = 1'b0;
      repeat (10) @(posedge clk);
      #1 rst_l = 1'b1;   // released just after an edge, like the other inputs
   end

endmodule

`default_nettype wire

/* verif/ecc_mem_assertions.sv */
// concurrent checks on the read port pipeline and its error counters
// bound into every ecc_read_port instance
`default_nettype none

module ecc_mem_assertions (
   input wire logic                            clk,
   input wire logic                            rst_l,
   input wire logic                            rd_en,
   input wire logic                            detect_only,
   input wire ecc_mem_pkg::rd_resp_t           rd_resp,
   input wire logic [ecc_mem_pkg::CNT_W-1:0]   single_count,
   input wire logic [ecc_mem_pkg::CNT_W-1:0]   double_count
);

   // store read plus decode register, response two cycles after the strobe
   a_resp_follows_strobe: assert property (@(posedge clk) disable iff (!rst_l)
      rd_resp.valid == $past(rd_en, 2))
      else $error("response valid does not follow the read strobe by two cycles");

   // the response was decoded one cycle before it shows up
   a_no_single_in_detect: assert property (@(posedge clk) disable iff (!rst_l)
      (rd_resp.valid && $past(detect_only)) |-> rd_resp.err_kind != ecc_mem_pkg::ERR_SINGLE)
      else $error("single error reported while detect-only mode was active");

   a_single_count_monotonic: assert property (@(posedge clk) disable iff (!rst_l)
      single_count >= $past(single_count))
      else $error("single error count went down");

   a_double_count_monotonic: assert property (@(posedge clk) disable iff (!rst_l)
      double_count >= $past(double_count))
      else $error("double error count went down");

endmodule

bind ecc_read_port ecc_mem_assertions u_assertions (
   .clk          (clk),
   .rst_l        (rst_l),
   .rd_en        (rd_en),
   .detect_only  (detect_only),
   .rd_resp      (rd_resp),
   .single_count (single_count),
   .double_count (double_count)
);

`default_nettype wire

/* verif/ecc_mem_tb.sv */
// directed testbench for the ECC word memory, with its own SEC-DED code model
// runs clean, single, double, detect-only, back-to-back and reset checks
`default_nettype none

module ecc_mem_tb;

   localparam int DEPTH      = 16;
   localparam int AW         = $clog2(DEPTH);
   localparam int MAX_CYCLES = 2000;   // tests need under 400 cycles after reset

   logic                             clk;
   logic                             rst_l;
   logic                             wr_en;
   logic [AW-1:0]                    wr_addr;
   logic [31:0]                      wr_data;
   logic [38:0]                      inject_mask;
   logic                             rd_en;
   logic [AW-1:0]                    rd_addr;
   logic                             detect_only;
   ecc_mem_pkg::rd_resp_t            rd_resp;
   logic [ecc_mem_pkg::CNT_W-1:0]    single_count;
   logic [ecc_mem_pkg::CNT_W-1:0]    double_count;

   int cycle_count = 0;
   int check_count = 0;
   int error_count = 0;
   int exp_single  = 0;
   int exp_double  = 0;

   ecc_mem_clk_gen u_clk_gen (.clk(clk), .rst_l(rst_l));

   ecc_mem_top #(.DEPTH(DEPTH)) dut (
      .clk          (clk),
      .rst_l        (rst_l),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .inject_mask  (inject_mask),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .detect_only  (detect_only),
      .rd_resp      (rd_resp),
      .single_count (single_count),
      .double_count (double_count)
   );

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("run stopped after %0d cycles without finishing the tests", cycle_count);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // code model, index p-1 holds code position p
   function automatic bit is_check_position(input int p);
      return (p & (p - 1)) == 0;
   endfunction

   function automatic logic [38:0] encode_positions(input logic [31:0] data);
      logic [38:0] cw;
      int          d;
      cw = '0;
      d  = 0;
      for (int p = 1; p <= 38; p++) begin
         if (!is_check_position(p)) begin
            cw[p-1] = data[d];
            d++;
         end
      end
      for (int k = 0; k < 6; k++) begin
         for (int p = 1; p <= 38; p++) begin
            if (!is_check_position(p) && ((p >> k) & 1) == 1) begin
               cw[(1 << k) - 1] = cw[(1 << k) - 1] ^ cw[p-1];
            end
         end
      end
      cw[38] = ^cw[37:0];   // overall parity over data and hamming bits
      return cw;
   endfunction

   function automatic logic [31:0] extract_data(input logic [38:0] cw);
      logic [31:0] data;
      int          d;
      data = '0;
      d    = 0;
      for (int p = 1; p <= 38; p++) begin
         if (!is_check_position(p)) begin
            data[d] = cw[p-1];
            d++;
         end
      end
      return data;
   endfunction

   // bit 6 is the parity of the whole received word
   function automatic logic [6:0] syndrome_of(input logic [38:0] cw);
      logic [38:0] fresh;
      logic [5:0]  ham;
      fresh = encode_positions(extract_data(cw));
      for (int k = 0; k < 6; k++) begin
         ham[k] = fresh[(1 << k) - 1] ^ cw[(1 << k) - 1];
      end
      return {^cw, ham};
   endfunction

   function automatic ecc_mem_pkg::err_kind_e model_kind(input logic [38:0] cw, input bit det);
      logic [6:0] s;
      s = syndrome_of(cw);
      if (det) begin
         return (s[5:0] != 6'd0) ? ecc_mem_pkg::ERR_DOUBLE : ecc_mem_pkg::ERR_NONE;
      end else if (s == 7'd0) begin
         return ecc_mem_pkg::ERR_NONE;
      end else if (s[6]) begin
         return ecc_mem_pkg::ERR_SINGLE;
      end
      return ecc_mem_pkg::ERR_DOUBLE;
   endfunction

   function automatic logic [31:0] model_data(input logic [38:0] cw, input bit det);
      logic [38:0] fixed;
      logic [6:0]  s;
      int          pos;
      fixed = cw;
      s     = syndrome_of(cw);
      pos   = int'(s[5:0]);
      if (!det && model_kind(cw, det) == ecc_mem_pkg::ERR_SINGLE && pos >= 1 && pos <= 39) begin
         fixed[pos-1] = ~fixed[pos-1];
      end
      return extract_data(fixed);
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Error: %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic write_word(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [38:0] mask);
      wr_en       = 1'b1;
      wr_addr     = addr;
      wr_data     = data;
      inject_mask = mask;
      step();
      wr_en       = 1'b0;
      inject_mask = '0;
   endtask

   // one read with the response expected exactly two cycles after the strobe
   task automatic read_check(input string name, input logic [AW-1:0] addr,
                             input logic [31:0] exp_data,
                             input ecc_mem_pkg::err_kind_e exp_kind, input bit with_data);
      rd_en   = 1'b1;
      rd_addr = addr;
      step();
      rd_en = 1'b0;
      check_value({name, " valid one cycle after strobe"}, 32'(1'b0), 32'(rd_resp.valid));
      step();
      if (exp_kind == ecc_mem_pkg::ERR_SINGLE) exp_single++;
      if (exp_kind == ecc_mem_pkg::ERR_DOUBLE) exp_double++;
      check_value({name, " valid"}, 32'(1'b1), 32'(rd_resp.valid));
      check_value({name, " err_kind"}, 32'(exp_kind), 32'(rd_resp.err_kind));
      if (with_data) check_value({name, " data"}, exp_data, rd_resp.data);
      check_value({name, " single_count"}, exp_single, 32'(single_count));
      check_value({name, " double_count"}, exp_double, 32'(double_count));
   endtask

   task automatic test_reset_state();
      check_value("reset_state valid", 32'(1'b0), 32'(rd_resp.valid));
      check_value("reset_state st_wr_en", 32'(1'b0), 32'(dut.u_write_port.st_wr_en));
      check_value("reset_state single_count", 32'(0), 32'(single_count));
      check_value("reset_state double_count", 32'(0), 32'(double_count));
   endtask

   task automatic test_clean_readback();
      logic [31:0] words [DEPTH];
      for (int a = 0; a < DEPTH; a++) begin
         words[a] = $urandom;
         write_word(AW'(a), words[a], '0);
      end
      step();
      for (int a = 0; a < DEPTH; a++) begin
         read_check("clean_readback", AW'(a), words[a], ecc_mem_pkg::ERR_NONE, 1'b1);
      end
      check_value("clean_readback single_count", 32'(0), 32'(single_count));
      check_value("clean_readback double_count", 32'(0), 32'(double_count));
   endtask

   task automatic test_single_correction();
      logic [AW-1:0] addr;
      logic [31:0]   data;
      logic [38:0]   mask;
      for (int pos = 0; pos < 39; pos++) begin   // every code position once
         addr      = AW'($urandom % DEPTH);
         data      = $urandom;
         mask      = '0;
         mask[pos] = 1'b1;
         write_word(addr, data, mask);
         step();
         read_check("single_correction", addr, data, ecc_mem_pkg::ERR_SINGLE, 1'b1);
      end
   endtask

   task automatic test_double_detect();
      logic [AW-1:0] addr;
      logic [38:0]   mask;
      int            p1;
      int            p2;
      for (int n = 0; n < 20; n++) begin
         addr = AW'($urandom % DEPTH);
         p1   = int'($urandom % 39);
         p2   = int'($urandom % 39);
         while (p2 == p1) p2 = int'($urandom % 39);
         mask     = '0;
         mask[p1] = 1'b1;
         mask[p2] = 1'b1;
         write_word(addr, $urandom, mask);
         step();
         read_check("double_detect", addr, 32'h0, ecc_mem_pkg::ERR_DOUBLE, 1'b0);
      end
   endtask

   task automatic test_detect_only();
      logic [AW-1:0] addr;
      logic [31:0]   data;
      logic [38:0]   mask;
      logic [38:0]   stored;
      detect_only = 1'b1;
      for (int n = 0; n < 12; n++) begin
         addr      = AW'($urandom % DEPTH);
         data      = $urandom;
         mask      = '0;
         mask[int'($urandom % 38)] = 1'b1;   // parity bit left out, hamming sees it
         stored    = encode_positions(data) ^ mask;
         write_word(addr, data, mask);
         step();
         read_check("detect_only", addr, model_data(stored, 1'b1),
                    model_kind(stored, 1'b1), 1'b1);
      end
      data   = $urandom;
      stored = encode_positions(data);
      write_word(AW'(0), data, '0);
      step();
      read_check("detect_only clean", AW'(0), model_data(stored, 1'b1),
                 model_kind(stored, 1'b1), 1'b1);
      detect_only = 1'b0;
   endtask

   task automatic test_back_to_back();
      logic [31:0] words [DEPTH];
      for (int a = 0; a < DEPTH; a++) begin
         words[a] = $urandom;
         write_word(AW'(a), words[a], '0);
      end
      step();
      for (int i = 0; i < DEPTH + 3; i++) begin
         if (i >= 2 && i < DEPTH + 2) begin
            check_value("back_to_back valid", 32'(1'b1), 32'(rd_resp.valid));
            check_value("back_to_back data", words[i-2], rd_resp.data);
            check_value("back_to_back err_kind", 32'(ecc_mem_pkg::ERR_NONE),
                        32'(rd_resp.err_kind));
         end else begin
            check_value("back_to_back idle valid", 32'(1'b0), 32'(rd_resp.valid));
         end
         rd_en   = (i < DEPTH);
         rd_addr = AW'(i % DEPTH);
         step();
      end
      check_value("back_to_back single_count", exp_single, 32'(single_count));
      check_value("back_to_back double_count", exp_double, 32'(double_count));
   endtask

   initial begin
      void'($urandom(32'h7a8f3fd1));
      wr_en       = 1'b0;
      wr_addr     = '0;
      wr_data     = '0;
      inject_mask = '0;
      rd_en       = 1'b0;
      rd_addr     = '0;
      detect_only = 1'b0;
      wait (rst_l === 1'b1);
      test_reset_state();   // must run before any read
      test_clean_readback();
      test_single_correction();
      test_double_detect();
      test_detect_only();
      test_back_to_back();
      $display("tests done: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/ecc_mem_pkg.sv
hw/ecc_write_port.sv
hw/ecc_word_store.sv
hw/ecc_read_port.sv
hw/ecc_mem_top.sv
verif/ecc_mem_clk_gen.sv
verif/ecc_mem_assertions.sv
verif/ecc_mem_tb.sv

/* Makefile */
# Verilator build and run of the ECC word memory testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module ecc_mem_tb \
		-f filelist.f --Mdir obj_dir -o ecc_mem_sim
	./obj_dir/ecc_mem_sim 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a status line"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
